// File: verilog/cpuPkg.sv
package cpuPkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // widths and register numbers.
  localparam int dataWidth = 32;
  localparam int regCount = 16;
  localparam int regIndexWidth = $clog2(regCount);

  typedef logic [dataWidth-1:0] wordT;
  typedef logic [regIndexWidth-1:0] regIndexT;

  // flag word bits are equal (0), less (1) and greater (2).
  localparam regIndexT flagReg = regIndexT'(1);

  // ~~~~~~~~~~~~~~~~~~~~
  // encodings.
  typedef enum logic [5:0] {
    opMove         = 6'd1,
    opLoadImm      = 6'd2,
    opLoadIndirect = 6'd3,
    opLoadOffset   = 6'd4,
    opLoadAbs      = 6'd6,
    opStoreAbs     = 6'd7,
    opStoreOffset  = 6'd8,
    opCompareReg   = 6'd13,
    opCompareImm   = 6'd14,
    opSetEqual     = 6'd15,
    opSetLess      = 6'd17,
    opJump         = 6'd19,
    opJumpNotEqual = 6'd20,
    opJumpEqual    = 6'd21,
    opJumpZero     = 6'd22,
    opJumpNonzero  = 6'd23,
    opAddImm       = 6'd28,
    opAdd          = 6'd29,
    opSubImm       = 6'd30,
    opSub          = 6'd31,
    opShiftLeft    = 6'd35,
    opShiftRight   = 6'd36
  } opcodeE;

  typedef enum logic [1:0] {memError = 2'd0, memBusy = 2'd1, memDone = 2'd2} memStatusE;

  typedef enum logic [1:0] {
    fetchFault    = 2'd0,
    dataWordFault = 2'd1,
    accessFault   = 2'd2,
    illegalOp     = 2'd3
  } haltCodeE;

  typedef enum logic [1:0] {memNone, memLoad, memStore} memKindE;

  typedef enum logic [2:0] {
    jumpNone,
    jumpAlways,
    jumpFlagEqualClear,
    jumpFlagEqualSet,
    jumpZero,
    jumpNonzero
  } jumpKindE;

  // ~~~~~~~~~~~~~~~~~~~~
  // structs.
  typedef struct packed {
    logic [7:0] fieldC;
    logic [7:0] fieldB;
    logic [7:0] fieldA;
    logic [1:0] reserved;
    logic [5:0] opcode;
  } instrT;

  typedef struct packed {
    opcodeE   opcode;
    regIndexT indexA;
    regIndexT indexB;
    regIndexT indexC;
    logic     hasDataWord;
    memKindE  memKind;
    jumpKindE jumpKind;
    logic     writesReg;
    logic     writesFlags;
    logic     legal;
  } decodedT;

  typedef struct packed {
    logic readStrobe;
    logic writeStrobe;
    wordT address;
    wordT writeData;
  } memRequestT;

  typedef struct packed {
    memStatusE status;
    wordT      readData;
  } memResponseT;

endpackage

// File: verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  cpuPkg::instrT   instr,
  output cpuPkg::decodedT decoded
);

  always_comb begin
    decoded = '0;
    decoded.opcode = cpuPkg::opcodeE'(instr.opcode);
    // only the low four bits of each field select a register.
    decoded.indexA = instr.fieldA[3:0];
    decoded.indexB = instr.fieldB[3:0];
    decoded.indexC = instr.fieldC[3:0];
    decoded.legal = 1'b1;
    case (instr.opcode)
      cpuPkg::opMove, cpuPkg::opSetEqual, cpuPkg::opSetLess, cpuPkg::opAdd,
      cpuPkg::opSub, cpuPkg::opShiftLeft, cpuPkg::opShiftRight: begin
        decoded.writesReg = 1'b1;
      end
      cpuPkg::opLoadImm, cpuPkg::opAddImm, cpuPkg::opSubImm: begin
        decoded.hasDataWord = 1'b1;
        decoded.writesReg = 1'b1;
      end
      cpuPkg::opLoadIndirect: begin
        decoded.memKind = cpuPkg::memLoad;
        decoded.writesReg = 1'b1;
      end
      cpuPkg::opLoadOffset, cpuPkg::opLoadAbs: begin
        decoded.hasDataWord = 1'b1;
        decoded.memKind = cpuPkg::memLoad;
        decoded.writesReg = 1'b1;
      end
      cpuPkg::opStoreAbs, cpuPkg::opStoreOffset: begin
        decoded.hasDataWord = 1'b1;
        decoded.memKind = cpuPkg::memStore;
      end
      cpuPkg::opCompareReg: begin
        decoded.writesFlags = 1'b1;
      end
      cpuPkg::opCompareImm: begin
        decoded.hasDataWord = 1'b1;
        decoded.writesFlags = 1'b1;
      end
      cpuPkg::opJump: begin
        decoded.hasDataWord = 1'b1;
        decoded.jumpKind = cpuPkg::jumpAlways;
      end
      // flag jumps read the flag word through port A.
      cpuPkg::opJumpNotEqual: begin
        decoded.hasDataWord = 1'b1;
        decoded.jumpKind = cpuPkg::jumpFlagEqualClear;
        decoded.indexA = cpuPkg::flagReg;
      end
      cpuPkg::opJumpEqual: begin
        decoded.hasDataWord = 1'b1;
        decoded.jumpKind = cpuPkg::jumpFlagEqualSet;
        decoded.indexA = cpuPkg::flagReg;
      end
      cpuPkg::opJumpZero: begin
        decoded.hasDataWord = 1'b1;
        decoded.jumpKind = cpuPkg::jumpZero;
      end
      cpuPkg::opJumpNonzero: begin
        decoded.hasDataWord = 1'b1;
        decoded.jumpKind = cpuPkg::jumpNonzero;
      end
      default: begin
        decoded.legal = 1'b0;
      end
    endcase
  end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::regIndexT readIndexA,
  input  cpuPkg::regIndexT readIndexB,
  input  cpuPkg::regIndexT readIndexC,
  output cpuPkg::wordT     readDataA,
  output cpuPkg::wordT     readDataB,
  output cpuPkg::wordT     readDataC,
  input  logic             writeEnable,
  input  cpuPkg::regIndexT writeIndex,
  input  cpuPkg::wordT     writeData
);

  cpuPkg::wordT regs [cpuPkg::regCount];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < cpuPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeIndex] <= writeData;
    end
  end

  // reads see the old value in a write cycle.
  assign readDataA = regs[readIndexA];
  assign readDataB = regs[readIndexB];
  assign readDataC = regs[readIndexC];

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
  input  cpuPkg::decodedT decoded,
  input  cpuPkg::wordT    operandA,
  input  cpuPkg::wordT    operandB,
  input  cpuPkg::wordT    operandC,
  input  cpuPkg::wordT    dataWord,
  input  cpuPkg::wordT    loadData,
  output cpuPkg::wordT    result,
  output cpuPkg::wordT    dataAddress,
  output logic            takeJump
);

  // unsigned compare packed into the flag word layout.
  function automatic cpuPkg::wordT flagWord(input cpuPkg::wordT lhs, input cpuPkg::wordT rhs);
    flagWord = '0;
    flagWord[0] = (lhs == rhs);
    flagWord[1] = (lhs < rhs);
    flagWord[2] = (lhs > rhs);
  endfunction

  always_comb begin
    case (decoded.opcode)
      cpuPkg::opMove:         result = operandB;
      cpuPkg::opLoadImm:      result = dataWord;
      cpuPkg::opLoadIndirect,
      cpuPkg::opLoadOffset,
      cpuPkg::opLoadAbs:      result = loadData;
      cpuPkg::opCompareReg:   result = flagWord(operandA, operandB);
      cpuPkg::opCompareImm:   result = flagWord(operandA, dataWord);
      cpuPkg::opSetEqual:     result = cpuPkg::wordT'(operandB == operandC);
      cpuPkg::opSetLess:      result = cpuPkg::wordT'(operandB < operandC);
      cpuPkg::opAddImm:       result = operandB + dataWord;
      cpuPkg::opAdd:          result = operandB + operandC;
      cpuPkg::opSubImm:       result = operandB - dataWord;
      cpuPkg::opSub:          result = operandB - operandC;
      cpuPkg::opShiftLeft:    result = operandB << operandC[4:0];
      cpuPkg::opShiftRight:   result = operandB >> operandC[4:0];
      default:                result = '0;
    endcase
  end

  always_comb begin
    case (decoded.opcode)
      cpuPkg::opLoadIndirect: dataAddress = operandB;
      cpuPkg::opLoadOffset:   dataAddress = dataWord + operandB;
      cpuPkg::opStoreOffset:  dataAddress = dataWord + operandA;
      default:                dataAddress = dataWord;
    endcase
  end

  // for flag jumps operandA carries the flag word.
  always_comb begin
    case (decoded.jumpKind)
      cpuPkg::jumpAlways:         takeJump = 1'b1;
      cpuPkg::jumpFlagEqualClear: takeJump = !operandA[0];
      cpuPkg::jumpFlagEqualSet:   takeJump = operandA[0];
      cpuPkg::jumpZero:           takeJump = (operandA == '0);
      cpuPkg::jumpNonzero:        takeJump = (operandA != '0);
      default:                    takeJump = 1'b0;
    endcase
  end

endmodule

// File: verilog/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
  input  logic                clk,
  input  logic                rstN,
  input  cpuPkg::memResponseT memResponse,
  output cpuPkg::memRequestT  memRequest,
  input  cpuPkg::decodedT     decoded,
  output cpuPkg::instrT       instrWord,
  input  cpuPkg::wordT        operandA,
  input  cpuPkg::wordT        operandB,
  input  cpuPkg::wordT        operandC,
  output cpuPkg::wordT        latchedA,
  output cpuPkg::wordT        latchedB,
  output cpuPkg::wordT        latchedC,
  output cpuPkg::wordT        dataWord,
  output cpuPkg::wordT        loadData,
  input  cpuPkg::wordT        result,
  input  cpuPkg::wordT        dataAddress,
  input  logic                takeJump,
  output logic                regWriteEnable,
  output cpuPkg::regIndexT    regWriteIndex,
  output cpuPkg::wordT        regWriteData,
  output logic                halted,
  output cpuPkg::haltCodeE    haltCode,
  output cpuPkg::wordT        haltData
);

  typedef enum logic [2:0] {
    stFetch,
    stFetchWait,
    stOperand,
    stDataWait,
    stAccess,
    stAccessWait,
    stWriteback,
    stHalt
  } stateE;

  stateE        state;
  cpuPkg::wordT ipointer;
  logic         readStrobe;
  logic         writeStrobe;
  cpuPkg::wordT requestAddress;
  cpuPkg::wordT requestData;
  logic         respDone;
  logic         respError;
  logic         needsAccess;
  cpuPkg::wordT nextPointer;

  assign respDone = (memResponse.status == cpuPkg::memDone);
  assign respError = (memResponse.status == cpuPkg::memError);
  assign needsAccess = (decoded.memKind != cpuPkg::memNone);
  assign nextPointer = takeJump ? dataWord : ipointer + (decoded.hasDataWord ? 32'd8 : 32'd4);

  // ~~~~~~~~~~~~~~~~~~~~
  // state, pointer, strobes and halt status.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stFetch;
      ipointer <= '0;
      readStrobe <= 1'b0;
      writeStrobe <= 1'b0;
      haltCode <= cpuPkg::fetchFault;
      haltData <= '0;
    end else begin
      // strobes last a single cycle.
      readStrobe <= 1'b0;
      writeStrobe <= 1'b0;
      case (state)
        stFetch: begin
          readStrobe <= 1'b1;
          state <= stFetchWait;
        end
        stFetchWait: begin
          if (respDone) begin
            state <= stOperand;
          end else if (respError) begin
            haltCode <= cpuPkg::fetchFault;
            haltData <= requestAddress;
            state <= stHalt;
          end
        end
        stOperand: begin
          if (!decoded.legal) begin
            haltCode <= cpuPkg::illegalOp;
            haltData <= ipointer;
            state <= stHalt;
          end else if (decoded.hasDataWord) begin
            readStrobe <= 1'b1;
            state <= stDataWait;
          end else if (needsAccess) begin
            state <= stAccess;
          end else begin
            state <= stWriteback;
          end
        end
        stDataWait: begin
          if (respDone) begin
            state <= needsAccess ? stAccess : stWriteback;
          end else if (respError) begin
            haltCode <= cpuPkg::dataWordFault;
            haltData <= requestAddress;
            state <= stHalt;
          end
        end
        stAccess: begin
          readStrobe <= (decoded.memKind == cpuPkg::memLoad);
          writeStrobe <= (decoded.memKind == cpuPkg::memStore);
          state <= stAccessWait;
        end
        stAccessWait: begin
          if (respDone) begin
            state <= stWriteback;
          end else if (respError) begin
            haltCode <= cpuPkg::accessFault;
            haltData <= requestAddress;
            state <= stHalt;
          end
        end
        stWriteback: begin
          ipointer <= nextPointer;
          readStrobe <= 1'b1;
          state <= stFetchWait;
        end
        default: begin
          state <= stHalt;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // per-instruction words and request payload.
  always_ff @(posedge clk) begin
    case (state)
      stFetch: begin
        requestAddress <= ipointer;
      end
      stFetchWait: begin
        if (respDone) begin
          instrWord <= cpuPkg::instrT'(memResponse.readData);
        end
      end
      stOperand: begin
        latchedA <= operandA;
        latchedB <= operandB;
        latchedC <= operandC;
        requestAddress <= ipointer + 32'd4;
      end
      stDataWait: begin
        if (respDone) begin
          dataWord <= memResponse.readData;
        end
      end
      stAccess: begin
        requestAddress <= dataAddress;
        requestData <= latchedB;
      end
      stAccessWait: begin
        if (respDone) begin
          loadData <= memResponse.readData;
        end
      end
      stWriteback: begin
        requestAddress <= nextPointer;
      end
      default: begin
      end
    endcase
  end

  assign memRequest = '{
    readStrobe: readStrobe,
    writeStrobe: writeStrobe,
    address: requestAddress,
    writeData: requestData
  };

  // compares go to the flag register, everything else to field A.
  assign regWriteEnable = (state == stWriteback) && (decoded.writesReg || decoded.writesFlags);
  assign regWriteIndex = decoded.writesFlags ? cpuPkg::flagReg : decoded.indexA;
  assign regWriteData = result;
  assign halted = (state == stHalt);

endmodule

// File: verilog/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
  input  logic                clk,
  input  logic                rstN,
  output cpuPkg::memRequestT  memRequest,
  input  cpuPkg::memResponseT memResponse,
  output logic                halted,
  output cpuPkg::haltCodeE    haltCode,
  output cpuPkg::wordT        haltData
);

  cpuPkg::instrT    instrWord;
  cpuPkg::decodedT  decoded;
  cpuPkg::wordT     operandA;
  cpuPkg::wordT     operandB;
  cpuPkg::wordT     operandC;
  cpuPkg::wordT     latchedA;
  cpuPkg::wordT     latchedB;
  cpuPkg::wordT     latchedC;
  cpuPkg::wordT     dataWord;
  cpuPkg::wordT     loadData;
  cpuPkg::wordT     result;
  cpuPkg::wordT     dataAddress;
  logic             takeJump;
  logic             regWriteEnable;
  cpuPkg::regIndexT regWriteIndex;
  cpuPkg::wordT     regWriteData;

  controlSequencer i_controlSequencer (
    .clk(clk),
    .rstN(rstN),
    .memResponse(memResponse),
    .memRequest(memRequest),
    .decoded(decoded),
    .instrWord(instrWord),
    .operandA(operandA),
    .operandB(operandB),
    .operandC(operandC),
    .latchedA(latchedA),
    .latchedB(latchedB),
    .latchedC(latchedC),
    .dataWord(dataWord),
    .loadData(loadData),
    .result(result),
    .dataAddress(dataAddress),
    .takeJump(takeJump),
    .regWriteEnable(regWriteEnable),
    .regWriteIndex(regWriteIndex),
    .regWriteData(regWriteData),
    .halted(halted),
    .haltCode(haltCode),
    .haltData(haltData)
  );

  instrDecoder i_instrDecoder (
    .instr(instrWord),
    .decoded(decoded)
  );

  // read ports are addressed straight from the decode.
  registerFile i_registerFile (
    .clk(clk),
    .rstN(rstN),
    .readIndexA(decoded.indexA),
    .readIndexB(decoded.indexB),
    .readIndexC(decoded.indexC),
    .readDataA(operandA),
    .readDataB(operandB),
    .readDataC(operandC),
    .writeEnable(regWriteEnable),
    .writeIndex(regWriteIndex),
    .writeData(regWriteData)
  );

  executeUnit i_executeUnit (
    .decoded(decoded),
    .operandA(latchedA),
    .operandB(latchedB),
    .operandC(latchedC),
    .dataWord(dataWord),
    .loadData(loadData),
    .result(result),
    .dataAddress(dataAddress),
    .takeJump(takeJump)
  );

endmodule

// File: test/cpuCore_checker.sv
`timescale 1ns/1ps

module cpuCore_checker (
  input logic                clk,
  input logic                rstN,
  input cpuPkg::memRequestT  memRequest,
  input cpuPkg::memResponseT memResponse,
  input logic                halted
);

  logic anyStrobe;
  logic pending;

  assign anyStrobe = memRequest.readStrobe || memRequest.writeStrobe;

  // a request is open from its strobe until done or error.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pending <= 1'b0;
    end else if (anyStrobe) begin
      pending <= 1'b1;
    end else if (memResponse.status != cpuPkg::memBusy) begin
      pending <= 1'b0;
    end
  end

  strobeOneCycle: assert property (@(posedge clk) disable iff (!rstN)
    anyStrobe |=> !anyStrobe)
    else $error("strobe held for more than one cycle");

  strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memRequest.readStrobe && memRequest.writeStrobe))
    else $error("read and write strobe high together");

  noStrobeWhilePending: assert property (@(posedge clk) disable iff (!rstN)
    pending |-> !anyStrobe)
    else $error("strobe issued while a request was still open");

  noStrobeWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
    halted |-> !anyStrobe)
    else $error("strobe issued while halted");

endmodule

// File: test/cpuCore_tb.sv
`timescale 1ns/1ps

module cpuCore_tb;

  logic                clk;
  logic                rstN = 1'b0;
  cpuPkg::memRequestT  memRequest;
  cpuPkg::memResponseT memResponse = '{status: cpuPkg::memBusy, readData: '0};
  logic                halted;
  cpuPkg::haltCodeE    haltCode;
  cpuPkg::wordT        haltData;

  // memory image, and a copy the reference works on.
  cpuPkg::wordT mem [1024];
  cpuPkg::wordT refMem [1024];
  cpuPkg::wordT faultLo;
  cpuPkg::wordT faultHi;
  cpuPkg::wordT asmPtr;
  cpuPkg::wordT storePtr;
  int           markerCount = 0;

  cpuPkg::wordT     expAddr [$];
  cpuPkg::wordT     expData [$];
  cpuPkg::haltCodeE expHaltCode;
  cpuPkg::wordT     expHaltData;

  logic [15:0] lfsrState = 16'd62175;
  string       testName = "none";
  int          checkCount = 0;
  int          valueErrors = 0;
  int          otherErrors = 0;
  int          cycleCount = 0;
  int          cycleLimit = 20;

  logic         pending = 1'b0;
  int           countdown = 0;
  logic         reqWrite;
  cpuPkg::wordT reqAddr;
  cpuPkg::wordT reqData;

  cpuCore i_cpuCore (
    .clk(clk),
    .rstN(rstN),
    .memRequest(memRequest),
    .memResponse(memResponse),
    .halted(halted),
    .haltCode(haltCode),
    .haltData(haltData)
  );

  bind cpuCore cpuCore_checker i_cpuCoreChecker (
    .clk(clk),
    .rstN(rstN),
    .memRequest(memRequest),
    .memResponse(memResponse),
    .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: %s did not halt within %0d cycles", testName, cycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // helpers.
  function automatic logic lfsrBit();
    logic feedback;
    feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
  endfunction

  function automatic cpuPkg::wordT randomBits(input int count);
    cpuPkg::wordT value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsrBit()};
    end
    return value;
  endfunction

  function automatic logic [9:0] memIndex(input cpuPkg::wordT addr);
    return addr[11:2];
  endfunction

  function automatic logic inFault(input cpuPkg::wordT addr);
    return (addr >= faultLo) && (addr < faultHi);
  endfunction

  task automatic checkWord(input string what, input cpuPkg::wordT expected,
                           input cpuPkg::wordT actual);
    checkCount++;
    if (expected !== actual) begin
      valueErrors++;
      $display("[ERROR] %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkHaltCode(input string what, input cpuPkg::haltCodeE expected,
                               input cpuPkg::haltCodeE actual);
    checkCount++;
    if (expected !== actual) begin
      valueErrors++;
      $display("[ERROR] %s %s: expected %s, actual %s", testName, what, expected.name(),
               actual.name());
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // memory model with random latency.
  always @(negedge clk) begin
    if (!rstN) begin
      pending = 1'b0;
      memResponse.status = cpuPkg::memBusy;
    end else begin
      memResponse.status = cpuPkg::memBusy;
      if (pending) begin
        if (countdown > 1) begin
          countdown--;
        end else begin
          pending = 1'b0;
          if (inFault(reqAddr)) begin
            memResponse.status = cpuPkg::memError;
          end else begin
            memResponse.status = cpuPkg::memDone;
            if (reqWrite) begin
              mem[memIndex(reqAddr)] = reqData;
            end else begin
              memResponse.readData = mem[memIndex(reqAddr)];
            end
          end
        end
      end
      if (memRequest.readStrobe || memRequest.writeStrobe) begin
        pending = 1'b1;
        reqWrite = memRequest.writeStrobe;
        reqAddr = memRequest.address;
        reqData = memRequest.writeData;
        countdown = int'(randomBits(2)) + 1;
      end
    end
  end

  // every store on the bus must be the next one the reference made.
  always @(negedge clk) begin
    if (rstN && memRequest.writeStrobe) begin
      if (expAddr.size() == 0) begin
        otherErrors++;
        $display("%s: store to %h that the reference does not make", testName,
                 memRequest.address);
      end else begin
        checkWord("store address", expAddr.pop_front(), memRequest.address);
        checkWord("store data", expData.pop_front(), memRequest.writeData);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // reference interpreter.
  function automatic void expectHalt(input cpuPkg::haltCodeE code, input cpuPkg::wordT data);
    expHaltCode = code;
    expHaltData = data;
  endfunction

  function automatic int runReference();
    cpuPkg::wordT     regs [16];
    cpuPkg::instrT    ins;
    cpuPkg::regIndexT ia;
    cpuPkg::wordT     ip;
    cpuPkg::wordT     nextIp;
    cpuPkg::wordT     dw;
    cpuPkg::wordT     addr;
    cpuPkg::wordT     ra;
    cpuPkg::wordT     rb;
    cpuPkg::wordT     rc;
    logic             hasDw;
    logic             legal;
    logic             done;
    int               steps;
    for (int i = 0; i < 1024; i++) begin
      refMem[i] = mem[i];
    end
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    expAddr.delete();
    expData.delete();
    ip = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 400) begin
      steps++;
      ins = cpuPkg::instrT'(refMem[memIndex(ip)]);
      ia = ins.fieldA[3:0];
      ra = regs[ins.fieldA[3:0]];
      rb = regs[ins.fieldB[3:0]];
      rc = regs[ins.fieldC[3:0]];
      legal = 1'b1;
      hasDw = 1'b1;
      case (ins.opcode)
        cpuPkg::opMove, cpuPkg::opLoadIndirect, cpuPkg::opCompareReg, cpuPkg::opSetEqual,
        cpuPkg::opSetLess, cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opShiftLeft,
        cpuPkg::opShiftRight: hasDw = 1'b0;
        cpuPkg::opLoadImm, cpuPkg::opLoadOffset, cpuPkg::opLoadAbs, cpuPkg::opStoreAbs,
        cpuPkg::opStoreOffset, cpuPkg::opCompareImm, cpuPkg::opJump, cpuPkg::opJumpNotEqual,
        cpuPkg::opJumpEqual, cpuPkg::opJumpZero, cpuPkg::opJumpNonzero, cpuPkg::opAddImm,
        cpuPkg::opSubImm: hasDw = 1'b1;
        default: legal = 1'b0;
      endcase
      dw = refMem[memIndex(ip + 32'd4)];
      nextIp = hasDw ? ip + 32'd8 : ip + 32'd4;
      addr = dw;
      if (ins.opcode == cpuPkg::opLoadIndirect) addr = rb;
      if (ins.opcode == cpuPkg::opLoadOffset) addr = dw + rb;
      if (ins.opcode == cpuPkg::opStoreOffset) addr = dw + ra;
      if (inFault(ip)) begin
        expectHalt(cpuPkg::fetchFault, ip);
        done = 1'b1;
      end else if (!legal) begin
        expectHalt(cpuPkg::illegalOp, ip);
        done = 1'b1;
      end else if (hasDw && inFault(ip + 32'd4)) begin
        expectHalt(cpuPkg::dataWordFault, ip + 32'd4);
        done = 1'b1;
      end else begin
        case (ins.opcode)
          cpuPkg::opMove:    regs[ia] = rb;
          cpuPkg::opLoadImm: regs[ia] = dw;
          cpuPkg::opLoadIndirect, cpuPkg::opLoadOffset, cpuPkg::opLoadAbs: begin
            if (inFault(addr)) begin
              expectHalt(cpuPkg::accessFault, addr);
              done = 1'b1;
            end else begin
              regs[ia] = refMem[memIndex(addr)];
            end
          end
          // the strobe is on the bus even when the store faults.
          cpuPkg::opStoreAbs, cpuPkg::opStoreOffset: begin
            expAddr.push_back(addr);
            expData.push_back(rb);
            if (inFault(addr)) begin
              expectHalt(cpuPkg::accessFault, addr);
              done = 1'b1;
            end else begin
              refMem[memIndex(addr)] = rb;
            end
          end
          cpuPkg::opCompareReg:   regs[cpuPkg::flagReg] = {29'd0, ra > rb, ra < rb, ra == rb};
          cpuPkg::opCompareImm:   regs[cpuPkg::flagReg] = {29'd0, ra > dw, ra < dw, ra == dw};
          cpuPkg::opSetEqual:     regs[ia] = (rb == rc) ? 32'd1 : 32'd0;
          cpuPkg::opSetLess:      regs[ia] = (rb < rc) ? 32'd1 : 32'd0;
          cpuPkg::opJump:         nextIp = dw;
          cpuPkg::opJumpNotEqual: if (!regs[cpuPkg::flagReg][0]) nextIp = dw;
          cpuPkg::opJumpEqual:    if (regs[cpuPkg::flagReg][0]) nextIp = dw;
          cpuPkg::opJumpZero:     if (ra == '0) nextIp = dw;
          cpuPkg::opJumpNonzero:  if (ra != '0) nextIp = dw;
          cpuPkg::opAddImm:       regs[ia] = rb + dw;
          cpuPkg::opAdd:          regs[ia] = rb + rc;
          cpuPkg::opSubImm:       regs[ia] = rb - dw;
          cpuPkg::opSub:          regs[ia] = rb - rc;
          cpuPkg::opShiftLeft:    regs[ia] = rb << rc[4:0];
          cpuPkg::opShiftRight:   regs[ia] = rb >> rc[4:0];
          default: begin
          end
        endcase
        ip = nextIp;
      end
    end
    return steps;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // program builder.
  task automatic startTest(input string name, input cpuPkg::wordT lo, input cpuPkg::wordT hi);
    testName = name;
    faultLo = lo;
    faultHi = hi;
    asmPtr = '0;
    storePtr = 32'h800;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h5EED0000 ^ cpuPkg::wordT'(i * 4);
    end
  endtask

  task automatic emit(input logic [5:0] op, input logic [7:0] a, input logic [7:0] b,
                      input logic [7:0] c);
    cpuPkg::instrT ins;
    ins = '{fieldC: c, fieldB: b, fieldA: a, reserved: 2'b00, opcode: op};
    mem[memIndex(asmPtr)] = ins;
    asmPtr += 32'd4;
  endtask

  task automatic emitData(input logic [5:0] op, input logic [7:0] a, input logic [7:0] b,
                          input logic [7:0] c, input cpuPkg::wordT dw);
    emit(op, a, b, c);
    mem[memIndex(asmPtr)] = dw;
    asmPtr += 32'd4;
  endtask

  task automatic storeReg(input logic [7:0] r);
    emitData(cpuPkg::opStoreAbs, 0, r, 0, storePtr);
    storePtr += 32'd4;
  endtask

  task automatic emitMarker();
    emitData(cpuPkg::opLoadImm, 5, 0, 0, 32'h100 + cpuPkg::wordT'(markerCount));
    storeReg(5);
    markerCount++;
  endtask

  // a taken jump skips the marker that follows it.
  task automatic jumpOverMarker(input logic [5:0] op, input logic [7:0] r);
    cpuPkg::wordT loc;
    loc = asmPtr;
    emitData(op, r, 0, 0, '0);
    emitMarker();
    mem[memIndex(loc + 32'd4)] = asmPtr;
  endtask

  task automatic applyReset();
    @(negedge clk);
    rstN = 1'b0;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
  endtask

  task automatic runProgram();
    int steps;
    steps = runReference();
    if (steps >= 400) begin
      otherErrors++;
      $display("%s: the reference interpreter never reached a halt", testName);
    end
    cycleLimit += steps * 20 + 12;
    applyReset();
    while (!halted) begin
      @(negedge clk);
    end
    if (expAddr.size() != 0) begin
      otherErrors++;
      $display("%s: %0d expected stores missing at the halt", testName, expAddr.size());
    end
    checkHaltCode("halt code", expHaltCode, haltCode);
    checkWord("halt data", expHaltData, haltData);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // tests.
  task automatic testArith();
    startTest("arith", 32'hF00, 32'hF40);
    emitData(cpuPkg::opLoadImm, 2, 0, 0, randomBits(32));
    emitData(cpuPkg::opLoadImm, 3, 0, 0, randomBits(32));
    emit(cpuPkg::opAdd, 4, 2, 3);
    emit(cpuPkg::opSub, 5, 2, 3);
    emitData(cpuPkg::opAddImm, 6, 4, 0, randomBits(32));
    emitData(cpuPkg::opSubImm, 7, 5, 0, randomBits(32));
    emit(cpuPkg::opMove, 8, 6, 0);
    storeReg(4);
    storeReg(5);
    emitData(cpuPkg::opLoadImm, 9, 0, 0, 32'h10);
    emitData(cpuPkg::opStoreOffset, 9, 6, 0, 32'h800);
    emitData(cpuPkg::opStoreOffset, 9, 7, 0, 32'h804);
    storeReg(8);
    emit(6'd0, 0, 0, 0);
    runProgram();
  endtask

  task automatic testLoads();
    startTest("loads", 32'hF00, 32'hF40);
    for (int i = 0; i < 4; i++) begin
      mem[memIndex(32'h900 + cpuPkg::wordT'(i * 4))] = randomBits(32);
    end
    emitData(cpuPkg::opLoadAbs, 2, 0, 0, 32'h900);
    emitData(cpuPkg::opLoadImm, 3, 0, 0, 32'h904);
    emit(cpuPkg::opLoadIndirect, 4, 3, 0);
    emitData(cpuPkg::opLoadImm, 5, 0, 0, 32'h8);
    // field B 0x35 selects register 5.
    emitData(cpuPkg::opLoadOffset, 6, 8'h35, 0, 32'h900);
    emit(cpuPkg::opAdd, 7, 2, 4);
    emit(cpuPkg::opSub, 8, 7, 6);
    emitData(cpuPkg::opAddImm, 9, 6, 0, randomBits(32));
    storeReg(7);
    storeReg(8);
    storeReg(9);
    storeReg(6);
    emit(6'd63, 0, 0, 0);
    runProgram();
  endtask

  task automatic testBranches();
    cpuPkg::wordT x;
    startTest("branches", 32'hF00, 32'hF40);
    x = randomBits(32);
    emitData(cpuPkg::opLoadImm, 2, 0, 0, x);
    emitData(cpuPkg::opLoadImm, 3, 0, 0, x);
    emit(cpuPkg::opCompareReg, 2, 3, 0);
    storeReg(1);
    jumpOverMarker(cpuPkg::opJumpNotEqual, 0);
    jumpOverMarker(cpuPkg::opJumpEqual, 0);
    emitData(cpuPkg::opCompareImm, 2, 0, 0, x + 32'd1);
    storeReg(1);
    jumpOverMarker(cpuPkg::opJumpEqual, 0);
    jumpOverMarker(cpuPkg::opJumpNotEqual, 0);
    emitData(cpuPkg::opLoadImm, 4, 0, 0, '0);
    jumpOverMarker(cpuPkg::opJumpZero, 4);
    jumpOverMarker(cpuPkg::opJumpNonzero, 4);
    emitData(cpuPkg::opLoadImm, 4, 0, 0, randomBits(32) | 32'd1);
    jumpOverMarker(cpuPkg::opJumpZero, 4);
    jumpOverMarker(cpuPkg::opJumpNonzero, 4);
    jumpOverMarker(cpuPkg::opJump, 0);
    emitMarker();
    emit(6'd0, 0, 0, 0);
    runProgram();
  endtask

  task automatic testShiftSet();
    startTest("shiftSet", 32'hF00, 32'hF40);
    for (int round = 0; round < 3; round++) begin
      emitData(cpuPkg::opLoadImm, 2, 0, 0, randomBits(32));
      emitData(cpuPkg::opLoadImm, 3, 0, 0, randomBits(32));
      emit(cpuPkg::opShiftLeft, 4, 2, 3);
      emit(cpuPkg::opShiftRight, 6, 2, 3);
      emit(cpuPkg::opSetEqual, 7, 2, 3);
      emit(cpuPkg::opSetLess, 8, 2, 3);
      emit(cpuPkg::opSetLess, 9, 3, 2);
      emit(cpuPkg::opMove, 11, 2, 0);
      emit(cpuPkg::opSetEqual, 10, 11, 2);
      emit(cpuPkg::opCompareReg, 2, 3, 0);
      storeReg(4);
      storeReg(6);
      storeReg(7);
      storeReg(8);
      storeReg(9);
      storeReg(10);
      storeReg(1);
    end
    emit(6'd40, 0, 0, 0);
    runProgram();
  endtask

  task automatic testFaults();
    startTest("storeFault", 32'hA00, 32'hA10);
    emitData(cpuPkg::opLoadImm, 2, 0, 0, randomBits(32));
    emitData(cpuPkg::opStoreAbs, 0, 2, 0, 32'hA04);
    emit(6'd0, 0, 0, 0);
    runProgram();

    startTest("fetchFault", 32'hA00, 32'hA10);
    emitData(cpuPkg::opLoadImm, 2, 0, 0, randomBits(32));
    emitData(cpuPkg::opJump, 0, 0, 0, 32'hA08);
    runProgram();

    // the data word of the instruction at 0xFC sits in the window.
    startTest("dataWordFault", 32'h100, 32'h110);
    emitData(cpuPkg::opJump, 0, 0, 0, 32'hFC);
    asmPtr = 32'hFC;
    emitData(cpuPkg::opLoadImm, 2, 0, 0, randomBits(32));
    runProgram();
  endtask

  initial begin
    testArith();
    testLoads();
    testBranches();
    testShiftSet();
    testFaults();
    $display("checks: %0d, value errors: %0d, other errors: %0d", checkCount, valueErrors,
             otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/executeUnit.sv
verilog/controlSequencer.sv
verilog/cpuCore.sv
test/cpuCore_checker.sv
test/cpuCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cpuCore_tb \
  -f compile.f -o cpuCoreSim
./obj_dir/cpuCoreSim | tee sim.log

if grep -qF "** PASS **" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
